//--- src/io_pkg.sv
/*
  I/O subsystem package
  word, address and error vector types
  I/O window address map, tick divider, process timer count
*/

package io_pkg;

  // ------------------------------
  // data types
  // ------------------------------

  // bus data word
  typedef logic [31:0] word_t;
  // word address inside the 64-word I/O window
  typedef logic [5:0]  io_addr_t;
  // program counter value captured on errors
  typedef logic [23:0] cpu_addr_t;
  // error signals into system control
  typedef logic [7:0]  err_vec_t;
  // process timer period, in ticks
  typedef logic [7:0]  ptmr_period_t;
  // watchdog timeout, in ticks
  typedef logic [15:0] wd_timeout_t;

  // ------------------------------
  // timing and sizes
  // ------------------------------

  // clocks per tick, scaled down for simulation
  localparam int TICK_DIV   = 8;
  localparam int TICK_CNT_W = $clog2(TICK_DIV);
  localparam int NUM_PTMR   = 8;

  // ------------------------------
  // address map, word addresses
  // ------------------------------
  localparam io_addr_t ADDR_PTMR = 6'd31;
  localparam io_addr_t ADDR_WD   = 6'd36;
  // two words, 46 and 47
  localparam io_addr_t ADDR_SCR  = 6'd46;
  localparam io_addr_t ADDR_TMR  = 6'd48;

endpackage

//--- src/ms_timer.sv
/*
  Millisecond timer
  tick prescaler, running tick count since reset
*/

`timescale 1ns/1ps

module ms_timer (
  input  logic          clk,
  input  logic          arst_n,
  input  logic          stb,
  output io_pkg::word_t rdata,
  output logic          ack,
  // one-cycle pulse every TICK_DIV clocks
  output logic          tick
);

  logic [io_pkg::TICK_CNT_W-1:0] pre_cnt;
  io_pkg::word_t                 ms_cnt;

  // ------------------------------
  // prescaler
  // ------------------------------
  // wraps after TICK_DIV clocks
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pre_cnt <= '0;
    end else if (tick) begin
      pre_cnt <= '0;
    end else begin
      pre_cnt <= pre_cnt + 1'b1;
    end
  end

  // high in the last clock of each period, so first on clock 8
  assign tick = (pre_cnt == io_pkg::TICK_CNT_W'(io_pkg::TICK_DIV - 1));

  // ------------------------------
  // tick counter
  // ------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ms_cnt <= '0;
    end else if (tick) begin
      ms_cnt <= ms_cnt + 1'b1;
    end
  end

  // read only, writes just get acked
  assign rdata = ms_cnt;
  assign ack   = stb;

endmodule

//--- src/watchdog.sv
/*
  Watchdog
  tick based timeout counter, trigger pulse on expiry
  timeout register, zero disables
*/

`timescale 1ns/1ps

module watchdog (
  input  logic          clk,
  input  logic          arst_n,
  input  logic          stb,
  input  logic          we,
  input  io_pkg::word_t wdata,
  input  logic          tick,
  output io_pkg::word_t rdata,
  output logic          ack,
  output logic          trig
);

  io_pkg::wd_timeout_t timeout;
  io_pkg::wd_timeout_t cnt;
  logic                wr;
  logic                en;

  assign wr = stb && we;
  assign en = (timeout != '0);

  // expiry on the tick that brings the count to the timeout
  assign trig = tick && en && (cnt == timeout - 1'b1);

  // ------------------------------
  // timeout and count
  // ------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      timeout <= '0;
      cnt     <= '0;
    end else if (wr) begin
      // a rewrite also serves as the kick
      timeout <= wdata[15:0];
      cnt     <= '0;
    end else if (trig) begin
      // restart for the next period
      cnt <= '0;
    end else if (tick && en) begin
      cnt <= cnt + 1'b1;
    end
  end

  // ------------------------------
  // bus side
  // ------------------------------
  assign rdata = {16'b0, timeout};
  assign ack   = stb;

endmodule

//--- src/proc_timers.sv
/*
  Process timers
  NUM_PTMR periodic tick counters with sticky ready bits
  period config writes, ready clear by mask
*/

`timescale 1ns/1ps

module proc_timers (
  input  logic          clk,
  input  logic          arst_n,
  input  logic          stb,
  input  logic          we,
  input  io_pkg::word_t wdata,
  input  logic          tick,
  output io_pkg::word_t rdata,
  output logic          ack
);

  io_pkg::ptmr_period_t        period [io_pkg::NUM_PTMR];
  io_pkg::ptmr_period_t        cnt    [io_pkg::NUM_PTMR];
  logic [io_pkg::NUM_PTMR-1:0] ready;
  logic [io_pkg::NUM_PTMR-1:0] done;
  logic [io_pkg::NUM_PTMR-1:0] cfg_hit;
  logic                        cfg_wr;
  logic                        clr_wr;
  logic [2:0]                  sel;

  // bit 31 chooses between period setup and ready clear
  assign cfg_wr = stb && we && !wdata[31];
  assign clr_wr = stb && we && wdata[31];
  assign sel    = wdata[18:16];

  // ------------------------------
  // per timer expiry
  // ------------------------------
  for (genvar g = 0; g < io_pkg::NUM_PTMR; g++) begin : g_done
    // a config write restarts the timer, so no expiry then
    assign cfg_hit[g] = cfg_wr && (sel == 3'(g));
    assign done[g]    = tick && !cfg_hit[g] && (period[g] != '0)
                        && (cnt[g] == period[g] - 1'b1);
  end

  // ------------------------------
  // counters, periods, ready bits
  // ------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < io_pkg::NUM_PTMR; i++) begin
        period[i] <= '0;
        cnt[i]    <= '0;
      end
      ready <= '0;
    end else begin
      for (int i = 0; i < io_pkg::NUM_PTMR; i++) begin
        if (cfg_hit[i]) begin
          period[i] <= wdata[7:0];
          cnt[i]    <= '0;
        end else if (done[i]) begin
          cnt[i] <= '0;
        end else if (tick && period[i] != '0) begin
          cnt[i] <= cnt[i] + 1'b1;
        end
        // a new expiry beats a clear in the same cycle
        if (done[i]) begin
          ready[i] <= 1'b1;
        end else if (clr_wr && wdata[i]) begin
          ready[i] <= 1'b0;
        end
      end
    end
  end

  assign rdata = {{(32 - io_pkg::NUM_PTMR){1'b0}}, ready};
  assign ack   = stb;

endmodule

//--- src/sys_ctrl.sv
/*
  System control
  error capture with cause and PC registers
  software reset and record clear, sys_rst pulse
*/

`timescale 1ns/1ps

module sys_ctrl (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              stb,
  input  logic              we,
  // 0 control and cause, 1 error address
  input  logic              sel,
  input  io_pkg::word_t     wdata,
  input  io_pkg::err_vec_t  err_in,
  input  io_pkg::cpu_addr_t pc_in,
  output io_pkg::word_t     rdata,
  output logic              ack,
  output logic              sys_rst
);

  io_pkg::err_vec_t  cause;
  io_pkg::cpu_addr_t err_addr;
  logic              rec;
  logic              err_hit;
  logic              ctl_wr;
  logic              rst_req;
  logic              rec_clr;

  // control writes only at address 0
  assign ctl_wr  = stb && we && !sel;
  assign rst_req = ctl_wr && wdata[0];
  assign rec_clr = ctl_wr && wdata[1];

  // only the first error is kept
  assign err_hit = !rec && (err_in != '0);

  // ------------------------------
  // error record
  // ------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rec      <= 1'b0;
      cause    <= '0;
      err_addr <= '0;
    end else if (err_hit) begin
      rec      <= 1'b1;
      cause    <= err_in;
      err_addr <= pc_in;
    end else if (rec_clr) begin
      rec      <= 1'b0;
      cause    <= '0;
      err_addr <= '0;
    end
  end

  // ------------------------------
  // reset request
  // ------------------------------
  // one clock, together with the capture or after the request write
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sys_rst <= 1'b0;
    end else begin
      sys_rst <= err_hit || rst_req;
    end
  end

  // ------------------------------
  // bus side
  // ------------------------------
  assign rdata = sel ? {8'b0, err_addr} : {24'b0, cause};
  assign ack   = stb;

endmodule

//--- src/io_sys.sv
/*
  I/O subsystem top level
  address decode into device strobes, error signal vector,
  read data and ack multiplexing
*/

`timescale 1ns/1ps

module io_sys (
  input  logic              clk,
  input  logic              arst_n,
  // bus from the CPU side
  input  logic              bus_stb,
  input  logic              bus_we,
  input  io_pkg::io_addr_t  bus_addr,
  input  io_pkg::word_t     bus_wdata,
  output io_pkg::word_t     bus_rdata,
  output logic              bus_ack,
  // external error sources and PC
  input  logic [1:0]        ext_err,
  input  io_pkg::cpu_addr_t pc_in,
  // reset request to the board reset block
  output logic              sys_rst
);

  // ms timer
  logic             tmr_stb;
  io_pkg::word_t    tmr_rdata;
  logic             tmr_ack;
  logic             tick;
  // watchdog
  logic             wd_stb;
  io_pkg::word_t    wd_rdata;
  logic             wd_ack;
  logic             wd_trig;
  // process timers
  logic             ptmr_stb;
  io_pkg::word_t    ptmr_rdata;
  logic             ptmr_ack;
  // system control
  logic             scr_stb;
  io_pkg::word_t    scr_rdata;
  logic             scr_ack;
  io_pkg::err_vec_t err_vec;

  // ------------------------------
  // address decoding
  // ------------------------------
  assign tmr_stb  = bus_stb && (bus_addr == io_pkg::ADDR_TMR);
  assign wd_stb   = bus_stb && (bus_addr == io_pkg::ADDR_WD);
  assign ptmr_stb = bus_stb && (bus_addr == io_pkg::ADDR_PTMR);
  // scr covers an aligned pair, bit 0 picks the register
  assign scr_stb  = bus_stb && (bus_addr[5:1] == io_pkg::ADDR_SCR[5:1]);

  // bit 0 wd, bits 1..2 external
  assign err_vec = {5'b0, ext_err, wd_trig};

  // ------------------------------
  // devices
  // ------------------------------
  ms_timer u_tmr (
    .clk    (clk),
    .arst_n (arst_n),
    .stb    (tmr_stb),
    .rdata  (tmr_rdata),
    .ack    (tmr_ack),
    .tick   (tick)
  );

  watchdog u_wd (
    .clk    (clk),
    .arst_n (arst_n),
    .stb    (wd_stb),
    .we     (bus_we),
    .wdata  (bus_wdata),
    .tick   (tick),
    .rdata  (wd_rdata),
    .ack    (wd_ack),
    .trig   (wd_trig)
  );

  proc_timers u_ptmr (
    .clk    (clk),
    .arst_n (arst_n),
    .stb    (ptmr_stb),
    .we     (bus_we),
    .wdata  (bus_wdata),
    .tick   (tick),
    .rdata  (ptmr_rdata),
    .ack    (ptmr_ack)
  );

  sys_ctrl u_scr (
    .clk     (clk),
    .arst_n  (arst_n),
    .stb     (scr_stb),
    .we      (bus_we),
    .sel     (bus_addr[0]),
    .wdata   (bus_wdata),
    .err_in  (err_vec),
    .pc_in   (pc_in),
    .rdata   (scr_rdata),
    .ack     (scr_ack),
    .sys_rst (sys_rst)
  );

  // ------------------------------
  // read data and ack muxing
  // ------------------------------
  // unmapped gives zero data, no ack
  assign bus_rdata =
    tmr_stb  ? tmr_rdata  :
    scr_stb  ? scr_rdata  :
    wd_stb   ? wd_rdata   :
    ptmr_stb ? ptmr_rdata :
    '0;

  assign bus_ack =
    tmr_stb  ? tmr_ack  :
    scr_stb  ? scr_ack  :
    wd_stb   ? wd_ack   :
    ptmr_stb ? ptmr_ack :
    1'b0;

endmodule

//--- testbench/clk_gen.sv
/*
  Testbench clock and reset
  8 ns clock, arst_n low for the first 8 cycles
*/

`timescale 1ns/1ps

module clk_gen (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // release on a falling edge, away from the active edge
  initial begin
    arst_n = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
  end

endmodule

//--- testbench/io_sys_tb.sv
/*
  I/O subsystem testbench
  row table of bus accesses, idle gaps and error pulses
  LFSR for pc_in and write data, value check, cycle limit
*/

`timescale 1ns/1ps

module io_sys_tb;

  // ------------------------------
  // table encoding
  // ------------------------------
  localparam logic [2:0] OP_RD   = 3'd0;
  localparam logic [2:0] OP_WR   = 3'd1;
  // write with LFSR data
  localparam logic [2:0] OP_WRR  = 3'd2;
  // data holds the cycle count
  localparam logic [2:0] OP_IDLE = 3'd3;
  // data holds ext_err for one cycle
  localparam logic [2:0] OP_ERR  = 3'd4;

  localparam logic [1:0] CHK_NONE = 2'd0;
  localparam logic [1:0] CHK_VAL  = 2'd1;
  // ticks since reset, from the cycle counter
  localparam logic [1:0] CHK_TMR  = 2'd2;
  // pc_in of the row where the error was recorded
  localparam logic [1:0] CHK_PC   = 2'd3;

  localparam io_pkg::io_addr_t A_TMR = io_pkg::ADDR_TMR;
  localparam io_pkg::io_addr_t A_WD  = io_pkg::ADDR_WD;
  localparam io_pkg::io_addr_t A_PT  = io_pkg::ADDR_PTMR;
  localparam io_pkg::io_addr_t A_SC0 = io_pkg::ADDR_SCR;
  localparam io_pkg::io_addr_t A_SC1 = io_pkg::ADDR_SCR + 6'd1;

  // x^32 + x^22 + x^2 + x + 1
  localparam io_pkg::word_t LFSR_MASK = 32'h8020_0003;
  localparam io_pkg::word_t LFSR_SEED = 32'd7;

  typedef struct packed {
    logic [2:0]       op;
    io_pkg::io_addr_t addr;
    io_pkg::word_t    data;
    logic [1:0]       chk;
    io_pkg::word_t    exp;
    logic             ack;
    // an error gets recorded during this row
    logic             cap;
    // sys_rst pulses seen before the row starts
    logic [3:0]       rst;
  } row_t;

  logic              clk;
  logic              arst_n;
  logic              bus_stb;
  logic              bus_we;
  io_pkg::io_addr_t  bus_addr;
  io_pkg::word_t     bus_wdata;
  io_pkg::word_t     bus_rdata;
  logic              bus_ack;
  logic [1:0]        ext_err;
  io_pkg::cpu_addr_t pc_in;
  logic              sys_rst;

  row_t              rows [$];
  io_pkg::word_t     lfsr;
  io_pkg::cpu_addr_t exp_pc;
  int                cyc = 0;
  int                limit = 0;
  int                rst_cnt = 0;

  clk_gen u_clk (.clk(clk), .arst_n(arst_n));

  io_sys UUT (
    .clk(clk), .arst_n(arst_n),
    .bus_stb(bus_stb), .bus_we(bus_we), .bus_addr(bus_addr),
    .bus_wdata(bus_wdata), .bus_rdata(bus_rdata), .bus_ack(bus_ack),
    .ext_err(ext_err), .pc_in(pc_in), .sys_rst(sys_rst)
  );

  // ------------------------------
  // cycle counter and pulse count
  // ------------------------------
  always @(posedge clk) begin
    if (arst_n) begin
      cyc <= cyc + 1;
    end
    if (limit > 0 && cyc > limit) begin
      $display("timeout: test still running after %0d cycles", limit);
      $display("*** TEST FAILED ***");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  // sys_rst is one full clock wide
  always @(negedge clk) begin
    if (sys_rst) begin
      rst_cnt <= rst_cnt + 1;
    end
  end

  // ------------------------------
  // helpers
  // ------------------------------
  function automatic io_pkg::word_t lfsr_step(input io_pkg::word_t s);
    if (s[0]) begin
      return (s >> 1) ^ LFSR_MASK;
    end
    return s >> 1;
  endfunction

  // one LFSR step per bit taken
  task automatic take_bits(input int n, output io_pkg::word_t v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  task automatic check(input string name, input io_pkg::word_t got,
                       input io_pkg::word_t exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic push_row(input logic [2:0] op, input io_pkg::io_addr_t addr,
                          input io_pkg::word_t data, input logic [1:0] chk,
                          input io_pkg::word_t exp, input logic ack,
                          input logic cap, input logic [3:0] rst);
    row_t r;
    r = '{op, addr, data, chk, exp, ack, cap, rst};
    rows.push_back(r);
  endtask

  // entered and left on a falling edge
  task automatic apply_row(input row_t r);
    io_pkg::word_t rnd;
    int            n;
    take_bits(24, rnd);
    pc_in = rnd[23:0];
    if (r.cap) begin
      exp_pc = rnd[23:0];
    end
    bus_stb   = (r.op == OP_RD) || (r.op == OP_WR) || (r.op == OP_WRR);
    bus_we    = (r.op == OP_WR) || (r.op == OP_WRR);
    bus_addr  = r.addr;
    bus_wdata = (r.op == OP_WR) ? r.data : '0;
    if (r.op == OP_WRR) begin
      take_bits(32, rnd);
      bus_wdata = rnd;
    end
    ext_err = (r.op == OP_ERR) ? r.data[1:0] : 2'b00;
    // read path is combinational, settle before sampling
    #2;
    check("sys_rst pulses", io_pkg::word_t'(rst_cnt), io_pkg::word_t'(r.rst));
    if (bus_stb) begin
      check("bus_ack", io_pkg::word_t'(bus_ack), io_pkg::word_t'(r.ack));
    end
    case (r.chk)
      CHK_VAL: check("bus_rdata", bus_rdata, r.exp);
      CHK_TMR: check("bus_rdata", bus_rdata, io_pkg::word_t'(cyc / io_pkg::TICK_DIV));
      CHK_PC:  check("bus_rdata", bus_rdata, {8'b0, exp_pc});
      default: ;
    endcase
    n = (r.op == OP_IDLE) ? int'(r.data) : 1;
    repeat (n) @(negedge clk);
  endtask

  // ------------------------------
  // stimulus table
  // ------------------------------
  task automatic build_table();
    // all registers clear after reset
    push_row(OP_RD,   A_TMR, 32'h0, CHK_VAL,  32'h0, 1'b1, 1'b0, 4'd0);
    push_row(OP_RD,   A_WD,  32'h0, CHK_VAL,  32'h0, 1'b1, 1'b0, 4'd0);
    push_row(OP_RD,   A_PT,  32'h0, CHK_VAL,  32'h0, 1'b1, 1'b0, 4'd0);
    push_row(OP_RD,   A_SC0, 32'h0, CHK_VAL,  32'h0, 1'b1, 1'b0, 4'd0);
    push_row(OP_RD,   A_SC1, 32'h0, CHK_VAL,  32'h0, 1'b1, 1'b0, 4'd0);
    // unmapped space, plus a timer write that has no effect
    push_row(OP_RD,   6'd0,  32'h0, CHK_VAL,  32'h0, 1'b0, 1'b0, 4'd0);
    push_row(OP_RD,   6'd63, 32'h0, CHK_VAL,  32'h0, 1'b0, 1'b0, 4'd0);
    push_row(OP_WRR,  6'd45, 32'h0, CHK_NONE, 32'h0, 1'b0, 1'b0, 4'd0);
    push_row(OP_WRR,  6'd49, 32'h0, CHK_NONE, 32'h0, 1'b0, 1'b0, 4'd0);
    push_row(OP_WRR,  A_TMR, 32'h0, CHK_NONE, 32'h0, 1'b1, 1'b0, 4'd0);
    push_row(OP_RD,   A_WD,  32'h0, CHK_VAL,  32'h0, 1'b1, 1'b0, 4'd0);
    push_row(OP_RD,   A_PT,  32'h0, CHK_VAL,  32'h0, 1'b1, 1'b0, 4'd0);
    push_row(OP_RD,   A_SC0, 32'h0, CHK_VAL,  32'h0, 1'b1, 1'b0, 4'd0);
    // ms timer
    push_row(OP_IDLE, 6'd0,  32'd13, CHK_NONE, 32'h0, 1'b0, 1'b0, 4'd0);
    push_row(OP_RD,   A_TMR, 32'h0, CHK_TMR,  32'h0, 1'b1, 1'b0, 4'd0);
    push_row(OP_IDLE, 6'd0,  32'd21, CHK_NONE, 32'h0, 1'b0, 1'b0, 4'd0);
    push_row(OP_RD,   A_TMR, 32'h0, CHK_TMR,  32'h0, 1'b1, 1'b0, 4'd0);
    // timer 1 every 8 ticks, 2 every 3, 5 every tick, 6 off
    push_row(OP_WR,   A_PT,  32'h0001_0008, CHK_NONE, 32'h0, 1'b1, 1'b0, 4'd0);
    push_row(OP_WR,   A_PT,  32'h0002_0003, CHK_NONE, 32'h0, 1'b1, 1'b0, 4'd0);
    push_row(OP_WR,   A_PT,  32'h0005_0001, CHK_NONE, 32'h0, 1'b1, 1'b0, 4'd0);
    push_row(OP_WR,   A_PT,  32'h0006_0000, CHK_NONE, 32'h0, 1'b1, 1'b0, 4'd0);
    // at most 5 ticks seen by timer 1 here
    push_row(OP_IDLE, 6'd0,  32'd32, CHK_NONE, 32'h0, 1'b0, 1'b0, 4'd0);
    push_row(OP_RD,   A_PT,  32'h0, CHK_VAL,  32'h24, 1'b1, 1'b0, 4'd0);
    push_row(OP_IDLE, 6'd0,  32'd40, CHK_NONE, 32'h0, 1'b0, 1'b0, 4'd0);
    push_row(OP_RD,   A_PT,  32'h0, CHK_VAL,  32'h26, 1'b1, 1'b0, 4'd0);
    // stop 2, 5 and 1 so no expiry races the clears
    push_row(OP_WR,   A_PT,  32'h0002_0000, CHK_NONE, 32'h0, 1'b1, 1'b0, 4'd0);
    push_row(OP_WR,   A_PT,  32'h0005_0000, CHK_NONE, 32'h0, 1'b1, 1'b0, 4'd0);
    push_row(OP_WR,   A_PT,  32'h0001_0000, CHK_NONE, 32'h0, 1'b1, 1'b0, 4'd0);
    push_row(OP_WR,   A_PT,  32'h8000_0004, CHK_NONE, 32'h0, 1'b1, 1'b0, 4'd0);
    push_row(OP_RD,   A_PT,  32'h0, CHK_VAL,  32'h22, 1'b1, 1'b0, 4'd0);
    push_row(OP_WR,   A_PT,  32'h8000_0022, CHK_NONE, 32'h0, 1'b1, 1'b0, 4'd0);
    push_row(OP_RD,   A_PT,  32'h0, CHK_VAL,  32'h0, 1'b1, 1'b0, 4'd0);
    // watchdog expires on the third tick, inside the idle row
    push_row(OP_WR,   A_WD,  32'd3, CHK_NONE, 32'h0, 1'b1, 1'b0, 4'd0);
    push_row(OP_RD,   A_WD,  32'h0, CHK_VAL,  32'd3, 1'b1, 1'b0, 4'd0);
    push_row(OP_IDLE, 6'd0,  32'd40, CHK_NONE, 32'h0, 1'b0, 1'b1, 4'd0);
    push_row(OP_RD,   A_SC0, 32'h0, CHK_VAL,  32'h1, 1'b1, 1'b0, 4'd1);
    push_row(OP_RD,   A_SC1, 32'h0, CHK_PC,   32'h0, 1'b1, 1'b0, 4'd1);
    push_row(OP_WR,   A_WD,  32'h0, CHK_NONE, 32'h0, 1'b1, 1'b0, 4'd1);
    // second error is dropped while the record holds
    push_row(OP_ERR,  6'd0,  32'h1, CHK_NONE, 32'h0, 1'b0, 1'b0, 4'd1);
    push_row(OP_RD,   A_SC0, 32'h0, CHK_VAL,  32'h1, 1'b1, 1'b0, 4'd1);
    push_row(OP_RD,   A_SC1, 32'h0, CHK_PC,   32'h0, 1'b1, 1'b0, 4'd1);
    // clear, then a fresh ext_err on bit 2
    push_row(OP_WR,   A_SC0, 32'h2, CHK_NONE, 32'h0, 1'b1, 1'b0, 4'd1);
    push_row(OP_RD,   A_SC0, 32'h0, CHK_VAL,  32'h0, 1'b1, 1'b0, 4'd1);
    push_row(OP_RD,   A_SC1, 32'h0, CHK_VAL,  32'h0, 1'b1, 1'b0, 4'd1);
    push_row(OP_ERR,  6'd0,  32'h2, CHK_NONE, 32'h0, 1'b0, 1'b1, 4'd1);
    push_row(OP_RD,   A_SC0, 32'h0, CHK_VAL,  32'h4, 1'b1, 1'b0, 4'd2);
    push_row(OP_RD,   A_SC1, 32'h0, CHK_PC,   32'h0, 1'b1, 1'b0, 4'd2);
    // software reset request, record stays
    push_row(OP_WR,   A_SC0, 32'h1, CHK_NONE, 32'h0, 1'b1, 1'b0, 4'd2);
    push_row(OP_IDLE, 6'd0,  32'd4, CHK_NONE, 32'h0, 1'b0, 1'b0, 4'd3);
    push_row(OP_RD,   A_SC0, 32'h0, CHK_VAL,  32'h4, 1'b1, 1'b0, 4'd3);
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    int cycles;
    bus_stb   = 1'b0;
    bus_we    = 1'b0;
    bus_addr  = '0;
    bus_wdata = '0;
    ext_err   = 2'b00;
    pc_in     = '0;
    exp_pc    = '0;
    lfsr      = LFSR_SEED;
    build_table();
    cycles = 0;
    foreach (rows[i]) begin
      cycles += (rows[i].op == OP_IDLE) ? int'(rows[i].data) : 1;
    end
    limit = 2 * cycles + 100;
    @(posedge arst_n);
    @(negedge clk);
    foreach (rows[i]) begin
      apply_row(rows[i]);
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

//--- files.f
src/io_pkg.sv
src/ms_timer.sv
src/watchdog.sv
src/proc_timers.sv
src/sys_ctrl.sv
src/io_sys.sv
testbench/clk_gen.sv
testbench/io_sys_tb.sv

//--- Makefile
TOP = io_sys_tb

.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 --top-module $(TOP) -f files.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
